// File: hw/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Core geometry
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5
`define DMEM_WORDS  64
`define RESET_PC    32'h0000_0000

`endif

// File: hw/rv_isa_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // Register-register ALU
        OPC_OP_IMM = 7'b0010011,  // ADDI only
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011   // BEQ only
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT} alu_op_e;

    // R-type layout; other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } rv_instr_t;

endpackage

`default_nettype wire

// File: hw/pipe_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package pipe_pkg;
    import rv_isa_pkg::*;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [31:0]       instr;
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1_value;
        logic [`XLEN-1:0]       rs2_value;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rd;
        alu_op_e                alu_op;
        logic                   alu_src_imm;  // Second operand is imm
        logic                   branch;
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       result;       // ALU value or RAM byte address
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       value;
    } commit_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: hw/register_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module register_bank import pipe_pkg::*; (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic [`REG_ADDR_W-1:0] rs1_addr,
    input  wire logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic      [`XLEN-1:0]       rs1_value,
    output logic      [`XLEN-1:0]       rs2_value,
    input  wire commit_t                write
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 reads zero; a write in flight is bypassed to the read
    assign rs1_value = (rs1_addr == '0) ? '0 :
                       (write.valid && write.rd == rs1_addr) ? write.value : regs[rs1_addr];
    assign rs2_value = (rs2_addr == '0) ? '0 :
                       (write.valid && write.rd == rs2_addr) ? write.value : regs[rs2_addr];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) regs[i] <= '0;
        end else if (write.valid && write.rd != '0) begin
            regs[write.rd] <= write.value;
        end
    end

endmodule

`default_nettype wire

// File: hw/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module data_ram (
    input  wire logic                            clock,
    input  wire logic                            reset,
    input  wire logic [$clog2(`DMEM_WORDS)-1:0]  addr,   // Word index
    input  wire logic [`XLEN-1:0]                wdata,
    input  wire logic                            we,
    output logic      [`XLEN-1:0]                rdata
);
    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    assign rdata = mem[addr];  // Async read

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) mem[i] <= '0;
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module fetch import pipe_pkg::*; (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             enable,
    output logic      [`XLEN-1:0] imem_addr,
    input  wire logic [31:0]      imem_data,
    input  wire redirect_t        redirect,
    output if_id_t                if_id
);
    logic [`XLEN-1:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc    <= `RESET_PC;
            if_id <= '0;
        end else if (enable) begin
            if (redirect.taken) begin
                pc    <= redirect.target;
                if_id <= '0;  // Drop the word fetched this cycle
            end else begin
                pc          <= pc + `XLEN'd4;
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.instr <= imem_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module decode import rv_isa_pkg::*, pipe_pkg::*; (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   enable,
    input  wire if_id_t                 if_id,
    input  wire logic                   flush,
    output logic      [`REG_ADDR_W-1:0] rs1_addr,
    output logic      [`REG_ADDR_W-1:0] rs2_addr,
    input  wire logic [`XLEN-1:0]       rs1_value,
    input  wire logic [`XLEN-1:0]       rs2_value,
    output id_ex_t                      id_ex
);
    rv_instr_t        instr;
    logic [31:0]      raw;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b;
    logic             known;
    id_ex_t           decoded;

    assign raw      = if_id.instr;
    assign instr    = rv_instr_t'(raw);
    assign rs1_addr = instr.rs1;
    assign rs2_addr = instr.rs2;

    assign imm_i = {{20{raw[31]}}, raw[31:20]};
    assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
    assign imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};

    always_comb begin
        decoded           = '0;
        known             = 1'b0;
        decoded.pc        = if_id.pc;
        decoded.rs1_value = rs1_value;
        decoded.rs2_value = rs2_value;
        decoded.rd        = instr.rd;
        decoded.alu_op    = ALU_ADD;  // Address math for LW/SW
        case (instr.opcode)
            OPC_OP: begin
                decoded.reg_write = 1'b1;
                known = (instr.funct7 == F7_BASE) ||
                        (instr.funct7 == F7_SUB && instr.funct3 == F3_ADD_SUB);
                case (instr.funct3)
                    F3_ADD_SUB: decoded.alu_op = (instr.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:     decoded.alu_op = ALU_SLT;
                    F3_XOR:     decoded.alu_op = ALU_XOR;
                    F3_OR:      decoded.alu_op = ALU_OR;
                    F3_AND:     decoded.alu_op = ALU_AND;
                    default:    known = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                known               = (instr.funct3 == F3_ADD_SUB);
                decoded.imm         = imm_i;
                decoded.alu_src_imm = 1'b1;
                decoded.reg_write   = 1'b1;
            end
            OPC_LOAD: begin
                known               = (instr.funct3 == F3_LW);
                decoded.imm         = imm_i;
                decoded.alu_src_imm = 1'b1;
                decoded.mem_read    = 1'b1;
                decoded.reg_write   = 1'b1;
            end
            OPC_STORE: begin
                known               = (instr.funct3 == F3_SW);
                decoded.imm         = imm_s;
                decoded.alu_src_imm = 1'b1;
                decoded.mem_write   = 1'b1;
            end
            OPC_BRANCH: begin
                known          = (instr.funct3 == F3_BEQ);
                decoded.imm    = imm_b;
                decoded.branch = 1'b1;
            end
            default: known = 1'b0;  // Unsupported opcode becomes a bubble
        endcase
        decoded.valid     = if_id.valid && known && !flush;
        decoded.reg_write = decoded.reg_write && (instr.rd != '0);
    end

    always_ff @(posedge clock) begin
        if (reset) id_ex <= '0;
        else if (enable) id_ex <= decoded;
    end

endmodule

`default_nettype wire

// File: hw/execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module execute import rv_isa_pkg::*, pipe_pkg::*; (
    input  wire logic   clock,
    input  wire logic   reset,
    input  wire logic   enable,
    input  wire id_ex_t id_ex,
    output redirect_t   redirect,
    output ex_mem_t     ex_mem
);
    logic [`XLEN-1:0] op_a, op_b;
    logic [`XLEN-1:0] result;

    assign op_a = id_ex.rs1_value;
    assign op_b = id_ex.alu_src_imm ? id_ex.imm : id_ex.rs2_value;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: result = op_a + op_b;
        endcase
    end

    // BEQ resolves here; also flushes fetch and decode
    assign redirect.taken  = id_ex.valid && id_ex.branch &&
                             (id_ex.rs1_value == id_ex.rs2_value);
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_mem <= '0;
        end else if (enable) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.result     <= result;
            ex_mem.store_data <= id_ex.rs2_value;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;
        end
    end

endmodule

`default_nettype wire

// File: hw/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module memory_stage import pipe_pkg::*; (
    input  wire logic                            clock,
    input  wire logic                            reset,
    input  wire logic                            enable,
    input  wire ex_mem_t                         ex_mem,
    output logic      [$clog2(`DMEM_WORDS)-1:0]  ram_addr,
    output logic      [`XLEN-1:0]                ram_wdata,
    output logic                                 ram_we,
    input  wire logic [`XLEN-1:0]                ram_rdata,
    output commit_t                              commit
);
    commit_t commit_q;  // Writeback register

    // Byte address to word index
    assign ram_addr  = ex_mem.result[$clog2(`DMEM_WORDS)+1:2];
    assign ram_wdata = ex_mem.store_data;
    assign ram_we    = enable && ex_mem.valid && ex_mem.mem_write;

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_q <= '0;
        end else if (enable) begin
            commit_q.valid <= ex_mem.valid && ex_mem.reg_write;
            commit_q.rd    <= ex_mem.rd;
            commit_q.value <= ex_mem.mem_read ? ram_rdata : ex_mem.result;
        end
    end

    // No strobe while the core is frozen
    assign commit.valid = commit_q.valid && enable;
    assign commit.rd    = commit_q.rd;
    assign commit.value = commit_q.value;

endmodule

`default_nettype wire

// File: hw/cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu import pipe_pkg::*; (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             enable,
    output logic      [`XLEN-1:0] imem_addr,
    input  wire logic [31:0]      imem_data,
    output commit_t               commit
);
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    redirect_t redirect;

    logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [`XLEN-1:0]       rs1_value, rs2_value;

    logic [$clog2(`DMEM_WORDS)-1:0] ram_addr;
    logic [`XLEN-1:0]               ram_wdata, ram_rdata;
    logic                           ram_we;

    fetch u_fetch (
        .clock, .reset, .enable,
        .imem_addr, .imem_data,
        .redirect,
        .if_id
    );

    decode u_decode (
        .clock, .reset, .enable,
        .if_id,
        .flush     (redirect.taken),  // Squash the instruction behind a taken BEQ
        .rs1_addr, .rs2_addr,
        .rs1_value, .rs2_value,
        .id_ex
    );

    execute u_execute (
        .clock, .reset, .enable,
        .id_ex,
        .redirect,
        .ex_mem
    );

    memory_stage u_memory (
        .clock, .reset, .enable,
        .ex_mem,
        .ram_addr, .ram_wdata, .ram_we, .ram_rdata,
        .commit
    );

    register_bank u_register_bank (
        .clock, .reset,
        .rs1_addr, .rs2_addr,
        .rs1_value, .rs2_value,
        .write     (commit)
    );

    data_ram u_data_ram (
        .clock, .reset,
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: verif/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_tb import pipe_pkg::*; ();
    localparam int          NUM_TESTS = 6;
    localparam int          STALL_CAP = 32;  // Most frozen cycles in one test
    localparam int          DRAIN     = 8;
    localparam logic [31:0] NOP       = 32'h0000_0013;  // ADDI x0, x0, 0

    typedef struct packed {
        logic [7:0] start;    // First word in the program store
        logic [7:0] len;
        logic [7:0] commits;  // Expected commit count
        logic [1:0] taken;    // Taken branches
        logic       stall;    // Random enable-low spans
    } test_row_t;

    logic             clock;
    logic             reset;
    logic             enable;
    logic [`XLEN-1:0] imem_addr;
    logic [31:0]      imem_data;
    commit_t          commit;

    logic [31:0] store [256];
    logic [31:0] prog  [256];
    test_row_t   rows  [NUM_TESTS];
    string       names [NUM_TESTS];
    commit_t     expected [64];  // Model commits in program order
    logic [31:0] expected_pc [64];
    int          expected_n;
    int          fill;
    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;
    logic [31:0] lcg_state;

    cpu UUT (
        .clock, .reset, .enable,
        .imem_addr, .imem_data,
        .commit
    );

    assign imem_data = (imem_addr < 32'd1024) ? prog[imem_addr[9:2]] : NOP;

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [11:0] random_imm();
        logic [31:0] r;
        r = next_random();
        return r[27:16];
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'h03};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] beq_insn(input logic [4:0] rs1, rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'h63};
    endfunction

    task automatic append_insn(input logic [31:0] insn);
        store[fill] = insn;
        fill++;
    endtask

    task automatic add_row(input int k, input string name, input int start, input int len,
                           input int commits, input int taken, input bit stall);
        names[k]        = name;
        rows[k].start   = 8'(start);
        rows[k].len     = 8'(len);
        rows[k].commits = 8'(commits);
        rows[k].taken   = 2'(taken);
        rows[k].stall   = stall;
    endtask

    task automatic build_programs();
        int base;
        fill = 0;
        base = fill;  // ALU ops on random seeds
        append_insn(addi(5'd1, 5'd0, random_imm()));
        append_insn(addi(5'd2, 5'd0, random_imm()));
        append_insn(addi(5'd3, 5'd0, random_imm()));
        append_insn(addi(5'd4, 5'd0, random_imm()));
        append_insn(r_type(7'h00, 3'b000, 5'd5, 5'd1, 5'd2));   // ADD
        append_insn(r_type(7'h20, 3'b000, 5'd6, 5'd1, 5'd2));   // SUB
        append_insn(r_type(7'h00, 3'b111, 5'd7, 5'd3, 5'd4));   // AND
        append_insn(r_type(7'h00, 3'b110, 5'd8, 5'd3, 5'd4));   // OR
        append_insn(r_type(7'h00, 3'b100, 5'd9, 5'd1, 5'd4));   // XOR
        append_insn(r_type(7'h00, 3'b010, 5'd10, 5'd1, 5'd2));  // SLT
        append_insn(r_type(7'h00, 3'b010, 5'd11, 5'd2, 5'd1));
        append_insn(r_type(7'h00, 3'b000, 5'd12, 5'd5, 5'd6));
        append_insn(addi(5'd13, 5'd5, random_imm()));
        add_row(0, "alu", base, fill - base, 13, 0, 1'b0);
        add_row(4, "stall", base, fill - base, 13, 0, 1'b1);  // Same program, frozen spans
        base = fill;
        append_insn(addi(5'd0, 5'd0, 12'h123));
        append_insn(addi(5'd1, 5'd0, 12'h055));
        append_insn(addi(5'd0, 5'd0, 12'h7ff));
        append_insn(r_type(7'h00, 3'b100, 5'd0, 5'd0, 5'd0));
        append_insn(r_type(7'h00, 3'b000, 5'd2, 5'd0, 5'd1));
        append_insn(r_type(7'h00, 3'b000, 5'd3, 5'd0, 5'd0));
        add_row(1, "x0", base, fill - base, 3, 0, 1'b0);
        base = fill;
        append_insn(addi(5'd3, 5'd0, 12'd16));  // Base address
        append_insn(addi(5'd1, 5'd0, random_imm()));
        append_insn(addi(5'd2, 5'd0, random_imm()));
        append_insn(addi(5'd4, 5'd0, random_imm()));
        append_insn(store_word(5'd1, 5'd3, 12'd0));
        append_insn(store_word(5'd2, 5'd3, 12'd4));
        append_insn(store_word(5'd4, 5'd3, 12'hff8));
        append_insn(store_word(5'd1, 5'd3, 12'd236));  // Last RAM word
        append_insn(load_word(5'd5, 5'd3, 12'd0));
        append_insn(load_word(5'd6, 5'd3, 12'd4));
        append_insn(load_word(5'd7, 5'd3, 12'hff8));
        append_insn(load_word(5'd8, 5'd3, 12'd236));
        append_insn(load_word(5'd9, 5'd3, 12'd12));   // Never written
        add_row(2, "store_load", base, fill - base, 9, 0, 1'b0);
        base = fill;
        append_insn(addi(5'd1, 5'd0, 12'd7));
        append_insn(addi(5'd2, 5'd0, 12'd7));
        append_insn(addi(5'd3, 5'd0, 12'd9));
        append_insn(NOP);
        append_insn(beq_insn(5'd1, 5'd2, 13'd16));  // Taken
        append_insn(addi(5'd4, 5'd0, 12'd1));       // Squashed in decode
        append_insn(addi(5'd5, 5'd0, 12'd2));       // Squashed in fetch
        append_insn(addi(5'd6, 5'd0, 12'd3));       // Skipped
        append_insn(beq_insn(5'd1, 5'd3, 13'd12));  // Not taken
        append_insn(addi(5'd7, 5'd0, 12'd4));
        append_insn(addi(5'd8, 5'd0, 12'd5));
        append_insn(r_type(7'h00, 3'b000, 5'd9, 5'd1, 5'd3));
        add_row(3, "branch", base, fill - base, 6, 1, 1'b0);
        base = fill;
        append_insn(NOP);
        append_insn(addi(5'd1, 5'd0, 12'h321));
        append_insn(addi(5'd2, 5'd0, 12'h111));
        append_insn(NOP);
        append_insn(NOP);
        append_insn(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        add_row(5, "timing", base, fill - base, 3, 0, 1'b0);
    endtask

    // Sequential RV32I subset model, fills the expected commit list
    task automatic model_program(input int len);
        logic [31:0] regs [32];
        logic [31:0] dmem [64];
        logic [31:0] ins, a, b, val, addr, imm_i, imm_s, imm_b;
        int          pc, next_pc, steps;
        bit          writes;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < 64; i++) dmem[i] = '0;
        expected_n = 0;
        pc         = 0;
        steps      = 0;
        while (pc < len * 4 && steps < 256) begin
            ins     = prog[pc / 4];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            next_pc = pc + 4;
            writes  = 1'b0;
            val     = '0;
            case (ins[6:0])
                7'h33: begin
                    writes = 1'b1;
                    case (ins[14:12])
                        3'b000:  val = ins[30] ? a - b : a + b;
                        3'b010:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100:  val = a ^ b;
                        3'b110:  val = a | b;
                        default: val = a & b;
                    endcase
                end
                7'h13: begin
                    writes = 1'b1;
                    val    = a + imm_i;
                end
                7'h03: begin
                    addr   = a + imm_i;
                    writes = 1'b1;
                    val    = dmem[addr[7:2]];
                end
                7'h23: begin
                    addr              = a + imm_s;
                    dmem[addr[7:2]] = b;
                end
                7'h63: if (a == b) next_pc = pc + imm_b;
                default: ;
            endcase
            if (writes && ins[11:7] != 5'd0 && expected_n < 64) begin
                regs[ins[11:7]]               = val;
                expected[expected_n].valid    = 1'b1;
                expected[expected_n].rd       = ins[11:7];
                expected[expected_n].value    = val;
                expected_pc[expected_n]       = pc;
                expected_n++;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic reset_dut();
        @(posedge clock);
        reset  <= 1'b1;
        enable <= 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic run_test(input int k);
        test_row_t   row;
        int          got, cycles, en_cycles, first_fetch, limit;
        int          stall_left, stall_total, errors_at_start;
        logic [31:0] r;
        row             = rows[k];
        errors_at_start = errors;
        for (int i = 0; i < 256; i++) begin
            prog[i] = (i < int'(row.len)) ? store[int'(row.start) + i] : NOP;
        end
        model_program(int'(row.len));
        limit       = int'(row.len) + 4 + 2 * int'(row.taken) + 8 + (row.stall ? STALL_CAP : 0);
        got         = 0;
        cycles      = 0;
        en_cycles   = 0;
        first_fetch = -1;
        stall_left  = 0;
        stall_total = 0;
        reset_dut();
        while (got < int'(row.commits) && cycles < limit) begin
            @(negedge clock);  // Outputs settled
            if (first_fetch < 0 && expected_n > 0 && imem_addr == expected_pc[0]) begin
                first_fetch = en_cycles;
            end
            if (commit.valid && !enable) begin
                $display("Test %s: commit strobe while enable is low", names[k]);
                errors++;
            end else if (commit.valid && got >= expected_n) begin
                $display("Test %s: extra commit to x%0d", names[k], commit.rd);
                errors++;
            end else if (commit.valid) begin
                if (commit.rd !== expected[got].rd) begin
                    $display("** Error %s: commit.rd expected %h, got %h",
                             names[k], expected[got].rd, commit.rd);
                    errors++;
                end
                if (commit.value !== expected[got].value) begin
                    $display("** Error %s: commit.value expected %h, got %h",
                             names[k], expected[got].value, commit.value);
                    errors++;
                end
                if (got == 0 && en_cycles - first_fetch != 4) begin
                    $display("** Error %s: first commit latency expected %h, got %h",
                             names[k], 4, en_cycles - first_fetch);
                    errors++;
                end
            end
            if (commit.valid) got++;
            if (enable) en_cycles++;
            cycles++;
            @(posedge clock);
            r = next_random();
            if (row.stall && stall_left == 0 && stall_total < STALL_CAP - 4 &&
                r[31:30] == 2'b00) begin
                stall_left = int'(r[29:28]) + 1;  // Span of 1 to 4 cycles
            end
            if (stall_left > 0) begin
                enable <= 1'b0;
                stall_left--;
                stall_total++;
            end else begin
                enable <= 1'b1;
            end
        end
        if (got < int'(row.commits)) begin
            $display("Test %s: timed out after %0d cycles, missing %0d of %0d commits",
                     names[k], cycles, int'(row.commits) - got, row.commits);
            errors++;
            timed_out = 1'b1;
        end else begin
            repeat (DRAIN) begin
                @(negedge clock);
                if (commit.valid) begin
                    $display("Test %s: extra commit to x%0d after the last expected one",
                             names[k], commit.rd);
                    errors++;
                end
                @(posedge clock);
                enable <= 1'b1;
            end
        end
        tests_run++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: ok, %0d commits", k, names[k], got);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAILED with %0d errors", k, names[k], errors - errors_at_start);
        end
    endtask

    initial begin
        reset        = 1'b1;
        enable       = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        lcg_state    = 32'h3557_9717;
        for (int i = 0; i < 256; i++) prog[i] = NOP;
        build_programs();
        for (int k = 0; k < NUM_TESTS && !timed_out; k++) run_test(k);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/pipe_pkg.sv
hw/register_bank.sv
hw/data_ram.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memory_stage.sv
hw/cpu.sv
verif/cpu_tb.sv

// File: Bender.yml
package:
  name: rv32i_pipeline

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_isa_pkg.sv
      - hw/pipe_pkg.sv
      - hw/register_bank.sv
      - hw/data_ram.sv
      - hw/fetch.sv
      - hw/decode.sv
      - hw/execute.sv
      - hw/memory_stage.sv
      - hw/cpu.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/cpu_tb.sv
